// File: Makefile
# Verilator flow for the MIPS execute stage
# Any variable below can be overridden, e.g. make test LOG=run2.log

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= mips_ex.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/alu.sv
`timescale 1ns/1ps
`include "mips_ex_settings.svh"

module alu
(
   ex_ctrl_if.alu                  i_ctrl,
   input  logic [`MIPS_DATA_W-1:0] i_op_a,
   input  logic [`MIPS_DATA_W-1:0] i_op_b,
   output logic [`MIPS_DATA_W-1:0] o_result,
   output logic                    o_zero
);

   logic [`MIPS_REG_W-1:0] shift_amt;
   logic                   a_lt_b;

   // Shifts see only the low five bits of B
   assign shift_amt = i_op_b[`MIPS_REG_W-1:0];

   // Signed compare for slt and slti
   assign a_lt_b = ($signed(i_op_a) < $signed(i_op_b));

   ////////////////////////////////////////
   // Operation decode
   ////////////////////////////////////////

   always_comb
   begin
      case (i_ctrl.alu_ctrl)
         mips_pkg::ALU_AND:
         begin
            o_result = i_op_a & i_op_b;             // and, andi
         end
         mips_pkg::ALU_OR:
         begin
            o_result = i_op_a | i_op_b;             // or, ori
         end
         mips_pkg::ALU_ADD:
         begin
            o_result = i_op_a + i_op_b;             // No overflow trap
         end
         mips_pkg::ALU_SUB:
         begin
            o_result = i_op_a - i_op_b;
         end
         mips_pkg::ALU_SLT:
         begin
            o_result = {{(`MIPS_DATA_W-1){1'b0}}, a_lt_b};
         end
         mips_pkg::ALU_XOR:
         begin
            o_result = i_op_a ^ i_op_b;             // xor, xori
         end
         mips_pkg::ALU_NOR:
         begin
            o_result = ~(i_op_a | i_op_b);
         end
         mips_pkg::ALU_SLL:
         begin
            o_result = i_op_a << shift_amt;         // sll, sllv, lui
         end
         mips_pkg::ALU_SRL:
         begin
            o_result = i_op_a >> shift_amt;
         end
         mips_pkg::ALU_SRA:
         begin
            // Sign bit fills from the left
            o_result = $unsigned($signed(i_op_a) >>> shift_amt);
         end
         default:
         begin
            o_result = i_op_a + i_op_b;             // Same fallback as unknown funct
         end
      endcase
   end

   assign o_zero = (o_result == '0); // beq condition

endmodule

// File: logic/alu_control.sv
`timescale 1ns/1ps

module alu_control
(
   input  mips_pkg::alu_op_t i_alu_op,
   input  mips_pkg::instr_u  i_instr,
   ex_ctrl_if.decoder        o_ctrl
);

   logic [5:0] funct;

   assign funct = i_instr.r.funct; // R view only

   always_comb
   begin
      // Register-register add unless told otherwise
      o_ctrl.alu_ctrl = mips_pkg::ALU_ADD;
      o_ctrl.a_src    = mips_pkg::A_REG_RS;
      o_ctrl.b_src    = mips_pkg::B_REG_RT;
      o_ctrl.dst_rd   = 1'b0;

      case (i_alu_op)
         mips_pkg::OP_RTYPE:
         begin
            o_ctrl.dst_rd = 1'b1;
            case (funct)
               mips_pkg::FUNCT_ADDU: o_ctrl.alu_ctrl = mips_pkg::ALU_ADD;
               mips_pkg::FUNCT_SUBU: o_ctrl.alu_ctrl = mips_pkg::ALU_SUB;
               mips_pkg::FUNCT_AND:  o_ctrl.alu_ctrl = mips_pkg::ALU_AND;
               mips_pkg::FUNCT_OR:   o_ctrl.alu_ctrl = mips_pkg::ALU_OR;
               mips_pkg::FUNCT_XOR:  o_ctrl.alu_ctrl = mips_pkg::ALU_XOR;
               mips_pkg::FUNCT_NOR:  o_ctrl.alu_ctrl = mips_pkg::ALU_NOR;
               mips_pkg::FUNCT_SLT:  o_ctrl.alu_ctrl = mips_pkg::ALU_SLT;
               // Fixed shifts of rt by shamt
               mips_pkg::FUNCT_SLL, mips_pkg::FUNCT_SRL, mips_pkg::FUNCT_SRA:
               begin
                  o_ctrl.a_src = mips_pkg::A_REG_RT;
                  o_ctrl.b_src = mips_pkg::B_SHAMT;
                  if (funct == mips_pkg::FUNCT_SLL)
                     o_ctrl.alu_ctrl = mips_pkg::ALU_SLL;
                  else if (funct == mips_pkg::FUNCT_SRL)
                     o_ctrl.alu_ctrl = mips_pkg::ALU_SRL;
                  else
                     o_ctrl.alu_ctrl = mips_pkg::ALU_SRA;
               end
               // Variable shifts of rt by rs[4:0]
               mips_pkg::FUNCT_SLLV, mips_pkg::FUNCT_SRLV, mips_pkg::FUNCT_SRAV:
               begin
                  o_ctrl.a_src = mips_pkg::A_REG_RT;
                  o_ctrl.b_src = mips_pkg::B_RS_LOW;
                  if (funct == mips_pkg::FUNCT_SLLV)
                     o_ctrl.alu_ctrl = mips_pkg::ALU_SLL;
                  else if (funct == mips_pkg::FUNCT_SRLV)
                     o_ctrl.alu_ctrl = mips_pkg::ALU_SRL;
                  else
                     o_ctrl.alu_ctrl = mips_pkg::ALU_SRA;
               end
               default: o_ctrl.alu_ctrl = mips_pkg::ALU_ADD; // Unknown funct adds
            endcase
         end
         mips_pkg::OP_ADD:
         begin
            o_ctrl.alu_ctrl = mips_pkg::ALU_ADD;
            o_ctrl.b_src    = mips_pkg::B_IMM_SEXT; // Address offset
         end
         mips_pkg::OP_SUB:
         begin
            o_ctrl.alu_ctrl = mips_pkg::ALU_SUB;    // Zero flag drives beq
         end
         mips_pkg::OP_ANDI:
         begin
            o_ctrl.alu_ctrl = mips_pkg::ALU_AND;
            o_ctrl.b_src    = mips_pkg::B_IMM_ZEXT;
         end
         mips_pkg::OP_ORI:
         begin
            o_ctrl.alu_ctrl = mips_pkg::ALU_OR;
            o_ctrl.b_src    = mips_pkg::B_IMM_ZEXT;
         end
         mips_pkg::OP_XORI:
         begin
            o_ctrl.alu_ctrl = mips_pkg::ALU_XOR;
            o_ctrl.b_src    = mips_pkg::B_IMM_ZEXT;
         end
         mips_pkg::OP_SLTI:
         begin
            o_ctrl.alu_ctrl = mips_pkg::ALU_SLT;
            o_ctrl.b_src    = mips_pkg::B_IMM_SEXT; // Signed compare
         end
         mips_pkg::OP_LUI:
         begin
            // imm16 << 16 through the shifter
            o_ctrl.alu_ctrl = mips_pkg::ALU_SLL;
            o_ctrl.a_src    = mips_pkg::A_IMM;
            o_ctrl.b_src    = mips_pkg::B_CONST16;
         end
         default:
         begin
            o_ctrl.alu_ctrl = mips_pkg::ALU_ADD;
         end
      endcase
   end

endmodule

// File: logic/ex_ctrl_if.sv
`timescale 1ns/1ps

// Decoded execute controls from decoder to datapath
interface ex_ctrl_if;

   mips_pkg::alu_ctrl_t alu_ctrl; // ALU operation code
   mips_pkg::a_src_t    a_src;    // Operand A mux select
   mips_pkg::b_src_t    b_src;    // Operand B mux select
   logic                dst_rd;   // Set to write rd instead of rt

   modport decoder
   (
      output alu_ctrl,
      output a_src,
      output b_src,
      output dst_rd
   );

   modport operand
   (
      input a_src,
      input b_src
   );

   modport alu
   (
      input alu_ctrl
   );

endinterface

// File: logic/ex_mem_latch.sv
`timescale 1ns/1ps
`include "mips_ex_settings.svh"

module ex_mem_latch
(
   input  logic                    i_clock,
   input  logic                    i_reset,
   input  logic                    i_stall,     // Hold everything
   input  logic                    i_valid,
   input  logic [`MIPS_DATA_W-1:0] i_result,
   input  logic                    i_zero,
   input  logic [`MIPS_DATA_W-1:0] i_rt_data,   // Store data for MEM
   input  logic [`MIPS_REG_W-1:0]  i_write_reg,
   output logic                    o_valid,
   output logic [`MIPS_DATA_W-1:0] o_result,
   output logic                    o_zero,
   output logic [`MIPS_DATA_W-1:0] o_rt_data,
   output logic [`MIPS_REG_W-1:0]  o_write_reg
);

   ////////////////////////////////////////
   // EX/MEM register
   ////////////////////////////////////////

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         // Bubble with clean payload
         o_valid     <= 1'b0;
         o_result    <= '0;
         o_zero      <= 1'b0;
         o_rt_data   <= '0;
         o_write_reg <= '0;
      end
      else if (!i_stall)
      begin
         o_valid     <= i_valid;     // Tracks the sampled valid
         o_result    <= i_result;
         o_zero      <= i_zero;
         o_rt_data   <= i_rt_data;
         o_write_reg <= i_write_reg;
      end
      // Stalled edge keeps the previous item in place
   end

endmodule

// File: logic/ex_operand_sel.sv
`timescale 1ns/1ps
`include "mips_ex_settings.svh"

module ex_operand_sel
(
   ex_ctrl_if.operand              i_ctrl,
   input  mips_pkg::instr_u        i_instr,
   input  logic [`MIPS_DATA_W-1:0] i_rs_data,
   input  logic [`MIPS_DATA_W-1:0] i_rt_data,
   output logic [`MIPS_DATA_W-1:0] o_op_a,
   output logic [`MIPS_DATA_W-1:0] o_op_b
);

   localparam int LUI_SHIFT = 16; // Upper half placement

   logic [15:0]             imm16;
   logic [`MIPS_DATA_W-1:0] imm_sext;
   logic [`MIPS_DATA_W-1:0] imm_zext;
   logic [`MIPS_DATA_W-1:0] shamt_ext;
   logic [`MIPS_DATA_W-1:0] rs_low;
   logic [`MIPS_DATA_W-1:0] const16;

   assign imm16    = i_instr.i.imm16;                              // I view
   assign imm_sext = {{(`MIPS_DATA_W-16){imm16[15]}}, imm16};
   assign imm_zext = {{(`MIPS_DATA_W-16){1'b0}}, imm16};
   assign shamt_ext = {{(`MIPS_DATA_W-`MIPS_REG_W){1'b0}}, i_instr.r.shamt}; // R view
   assign rs_low   = {{(`MIPS_DATA_W-`MIPS_REG_W){1'b0}}, i_rs_data[`MIPS_REG_W-1:0]};
   assign const16  = `MIPS_DATA_W'(LUI_SHIFT);

   ////////////////////////////////////////
   // Operand A
   ////////////////////////////////////////

   always_comb
   begin
      case (i_ctrl.a_src)
         mips_pkg::A_REG_RS: o_op_a = i_rs_data;
         mips_pkg::A_REG_RT: o_op_a = i_rt_data; // Shift source
         mips_pkg::A_IMM:    o_op_a = imm_zext;  // LUI
         default:            o_op_a = i_rs_data;
      endcase
   end

   ////////////////////////////////////////
   // Operand B
   ////////////////////////////////////////

   always_comb
   begin
      case (i_ctrl.b_src)
         mips_pkg::B_REG_RT:   o_op_b = i_rt_data;
         mips_pkg::B_IMM_SEXT: o_op_b = imm_sext;  // addi, lw, sw, slti
         mips_pkg::B_IMM_ZEXT: o_op_b = imm_zext;  // Logic immediates
         mips_pkg::B_SHAMT:    o_op_b = shamt_ext;
         mips_pkg::B_RS_LOW:   o_op_b = rs_low;    // Only 5 bits count
         mips_pkg::B_CONST16:  o_op_b = const16;
         default:              o_op_b = i_rt_data;
      endcase
   end

endmodule

// File: logic/ex_stage.sv
`timescale 1ns/1ps
`include "mips_ex_settings.svh"

module ex_stage
(
   input  logic                    i_clock,
   input  logic                    i_reset,
   input  logic                    i_valid,
   input  logic                    i_stall,
   input  logic [2:0]              i_alu_op,    // Class from main control
   input  logic [`MIPS_DATA_W-1:0] i_instr,
   input  logic [`MIPS_DATA_W-1:0] i_rs_data,
   input  logic [`MIPS_DATA_W-1:0] i_rt_data,
   output logic                    o_valid,
   output logic [`MIPS_DATA_W-1:0] o_result,
   output logic                    o_zero,
   output logic [`MIPS_DATA_W-1:0] o_rt_data,
   output logic [`MIPS_REG_W-1:0]  o_write_reg
);

   mips_pkg::instr_u        instr;
   mips_pkg::alu_op_t       alu_op;
   logic [`MIPS_DATA_W-1:0] op_a;
   logic [`MIPS_DATA_W-1:0] op_b;
   logic [`MIPS_DATA_W-1:0] alu_result;
   logic                    alu_zero;
   logic [`MIPS_REG_W-1:0]  write_reg;

   assign instr  = i_instr;
   assign alu_op = mips_pkg::alu_op_t'(i_alu_op);

   ex_ctrl_if ctrl ();

   ////////////////////////////////////////
   // Combinational execute path
   ////////////////////////////////////////

   alu_control u_alu_control (.i_alu_op(alu_op), .i_instr(instr), .o_ctrl(ctrl));

   ex_operand_sel u_operand_sel
   (
      .i_ctrl    (ctrl),
      .i_instr   (instr),
      .i_rs_data (i_rs_data),
      .i_rt_data (i_rt_data),
      .o_op_a    (op_a),
      .o_op_b    (op_b)
   );

   alu u_alu (.i_ctrl(ctrl), .i_op_a(op_a), .i_op_b(op_b), .o_result(alu_result),
              .o_zero(alu_zero));

   // R-type writes rd, everything else rt
   assign write_reg = ctrl.dst_rd ? instr.r.rd : instr.r.rt;

   ex_mem_latch u_ex_mem
   (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .i_stall     (i_stall),
      .i_valid     (i_valid),
      .i_result    (alu_result),
      .i_zero      (alu_zero),
      .i_rt_data   (i_rt_data),
      .i_write_reg (write_reg),
      .o_valid     (o_valid),
      .o_result    (o_result),
      .o_zero      (o_zero),
      .o_rt_data   (o_rt_data),
      .o_write_reg (o_write_reg)
   );

endmodule

// File: logic/mips_ex_settings.svh
`ifndef MIPS_EX_SETTINGS_SVH
`define MIPS_EX_SETTINGS_SVH

// Datapath word width
`define MIPS_DATA_W 32

// ALU control code width for the funct-derived code set
`define MIPS_ALU_CTRL_W 4

// Register index width (rs, rt, rd and shamt fields)
`define MIPS_REG_W 5

`endif

// File: logic/mips_pkg.sv
`include "mips_ex_settings.svh"

package mips_pkg;

   ////////////////////////////////////////
   // ALU codes and control classes
   ////////////////////////////////////////

   typedef enum logic [`MIPS_ALU_CTRL_W-1:0]
   {
      ALU_AND = 4'b0000,
      ALU_OR  = 4'b0001,
      ALU_ADD = 4'b0010,
      ALU_SUB = 4'b0110,
      ALU_SLT = 4'b0111,
      ALU_XOR = 4'b1001,
      ALU_NOR = 4'b1010,
      ALU_SLL = 4'b1011,
      ALU_SRL = 4'b1100,
      ALU_SRA = 4'b1101
   } alu_ctrl_t;

   // Class sent by the main control
   typedef enum logic [2:0]
   {
      OP_RTYPE, // Code comes from funct
      OP_ADD,   // Loads, stores, addi
      OP_SUB,   // beq compare
      OP_ANDI,
      OP_ORI,
      OP_XORI,
      OP_SLTI,
      OP_LUI
   } alu_op_t;

   typedef enum logic [2:0]
   {
      B_REG_RT,
      B_IMM_SEXT,
      B_IMM_ZEXT,
      B_SHAMT,
      B_RS_LOW,  // Variable shift amount
      B_CONST16  // LUI shift amount
   } b_src_t;

   typedef enum logic [1:0]
   {
      A_REG_RS,
      A_REG_RT,
      A_IMM     // Zero-extended immediate for LUI
   } a_src_t;

   ////////////////////////////////////////
   // Instruction word views
   ////////////////////////////////////////

   typedef struct packed
   {
      logic [5:0]             opcode;
      logic [`MIPS_REG_W-1:0] rs;
      logic [`MIPS_REG_W-1:0] rt;
      logic [`MIPS_REG_W-1:0] rd;
      logic [`MIPS_REG_W-1:0] shamt;
      logic [5:0]             funct;
   } r_fields_t;

   typedef struct packed
   {
      logic [5:0]             opcode;
      logic [`MIPS_REG_W-1:0] rs;
      logic [`MIPS_REG_W-1:0] rt;
      logic [15:0]            imm16;
   } i_fields_t;

   // Same 32 bits decoded two ways
   typedef union packed
   {
      r_fields_t r;
      i_fields_t i;
   } instr_u;

   // Function field values
   localparam logic [5:0] FUNCT_SLL  = 6'h00;
   localparam logic [5:0] FUNCT_SRL  = 6'h02;
   localparam logic [5:0] FUNCT_SRA  = 6'h03;
   localparam logic [5:0] FUNCT_SLLV = 6'h04;
   localparam logic [5:0] FUNCT_SRLV = 6'h06;
   localparam logic [5:0] FUNCT_SRAV = 6'h07;
   localparam logic [5:0] FUNCT_ADDU = 6'h21;
   localparam logic [5:0] FUNCT_SUBU = 6'h23;
   localparam logic [5:0] FUNCT_AND  = 6'h24;
   localparam logic [5:0] FUNCT_OR   = 6'h25;
   localparam logic [5:0] FUNCT_XOR  = 6'h26;
   localparam logic [5:0] FUNCT_NOR  = 6'h27;
   localparam logic [5:0] FUNCT_SLT  = 6'h2a;

endpackage

// File: mips_ex.f
+incdir+logic
logic/mips_pkg.sv
logic/ex_ctrl_if.sv
logic/alu_control.sv
logic/ex_operand_sel.sv
logic/alu.sv
logic/ex_mem_latch.sv
logic/ex_stage.sv
tb/clock_gen.sv
tb/ex_stage_sva.sv
tb/ex_stage_tb.sv

// File: tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen
(
   output logic o_clock,
   output logic o_reset
);

   localparam int HALF_NS      = 5; // 10 ns period
   localparam int RESET_CYCLES = 5;

   initial
   begin
      o_clock = 1'b0;
      forever #(HALF_NS) o_clock = ~o_clock;
   end

   initial
   begin
      o_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clock);
      o_reset <= 1'b0; // Drops just after the fifth reset edge
   end

endmodule

// File: tb/ex_stage_sva.sv
`timescale 1ns/1ps
`include "mips_ex_settings.svh"

module ex_stage_sva
(
   input logic                    i_clock,
   input logic                    i_reset,
   input logic                    i_stall,
   input logic                    o_valid,
   input logic [`MIPS_DATA_W-1:0] o_result,
   input logic                    o_zero,
   input logic [`MIPS_DATA_W-1:0] o_rt_data,
   input logic [`MIPS_REG_W-1:0]  o_write_reg
);

   // Reset always leaves a bubble
   reset_gives_bubble: assert property (@(posedge i_clock) i_reset |=> !o_valid)
      else $error("o_valid high in the cycle after reset");

   // Stall freezes the whole EX/MEM register
   stall_holds: assert property (@(posedge i_clock) disable iff (i_reset)
      i_stall |=> $stable({o_valid, o_result, o_zero, o_rt_data, o_write_reg}))
      else $error("EX/MEM outputs changed across a stalled edge");

   zero_flag_match: assert property (@(posedge i_clock) disable iff (i_reset)
      o_valid |-> (o_zero == (o_result == '0)))
      else $error("o_zero disagrees with o_result");

endmodule

bind ex_stage ex_stage_sva sva0
(
   .i_clock     (i_clock),
   .i_reset     (i_reset),
   .i_stall     (i_stall),
   .o_valid     (o_valid),
   .o_result    (o_result),
   .o_zero      (o_zero),
   .o_rt_data   (o_rt_data),
   .o_write_reg (o_write_reg)
);

// File: tb/ex_stage_tb.sv
`timescale 1ns/1ps
`include "mips_ex_settings.svh"

module ex_stage_tb;

   localparam int RESET_LIMIT = 20;    // Cycles allowed for reset release
   localparam int WATCHDOG_NS = 20000;
   localparam int RANDOM_ROWS = 24;
   localparam logic [5:0] FUNCT_SET [0:13] = '{mips_pkg::FUNCT_ADDU, mips_pkg::FUNCT_SUBU,
      mips_pkg::FUNCT_AND, mips_pkg::FUNCT_OR, mips_pkg::FUNCT_XOR, mips_pkg::FUNCT_NOR,
      mips_pkg::FUNCT_SLT, mips_pkg::FUNCT_SLL, mips_pkg::FUNCT_SRL, mips_pkg::FUNCT_SRA,
      mips_pkg::FUNCT_SLLV, mips_pkg::FUNCT_SRLV, mips_pkg::FUNCT_SRAV, 6'h3e}; // Last unknown

   typedef struct
   {
      string       name;
      logic [31:0] instr;
      logic [2:0]  op;
      logic [31:0] rs;
      logic [31:0] rt;
      logic        stall;
      logic        valid;
   } row_t;

   logic clock, rst_gen, rst_tb, reset;
   logic i_valid, i_stall;
   logic [2:0] i_alu_op;
   logic [`MIPS_DATA_W-1:0] i_instr, i_rs_data, i_rt_data, o_result, o_rt_data;
   logic o_valid, o_zero;
   logic [`MIPS_REG_W-1:0] o_write_reg;

   logic exp_valid, exp_zero;           // Expected EX/MEM contents
   logic [31:0] exp_result, exp_rt;
   logic [4:0] exp_wreg;
   int errors, checks, row_errs;
   logic [31:0] lfsr_state;
   row_t rows[$];

   clock_gen clk0 (.o_clock(clock), .o_reset(rst_gen));
   assign reset = rst_gen | rst_tb;     // Extra reset for the mid-run case

   ex_stage dut0 (.i_clock(clock), .i_reset(reset), .i_valid(i_valid), .i_stall(i_stall),
      .i_alu_op(i_alu_op), .i_instr(i_instr), .i_rs_data(i_rs_data), .i_rt_data(i_rt_data),
      .o_valid(o_valid), .o_result(o_result), .o_zero(o_zero), .o_rt_data(o_rt_data),
      .o_write_reg(o_write_reg));

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////

   // Fibonacci taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_state = lfsr_next(lfsr_state); // One step per bit
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   task automatic add_row(string name, logic [31:0] instr, logic [2:0] op, logic [31:0] rs,
                          logic [31:0] rt, logic stall, logic valid);
      row_t r;
      r = '{name, instr, op, rs, rt, stall, valid};
      rows.push_back(r);
   endtask

   // R-type with rd varying per row
   task automatic add_r(string name, logic [5:0] fn, logic [4:0] sh, logic [31:0] rs,
                        logic [31:0] rt);
      add_row(name, {6'h00, 5'd1, 5'd2, 5'(rows.size() + 3), sh, fn}, mips_pkg::OP_RTYPE,
              rs, rt, 1'b0, 1'b1);
   endtask

   task automatic add_i(string name, logic [2:0] op, logic [15:0] imm, logic [31:0] rs,
                        logic [31:0] rt);
      add_row(name, {6'h08, 5'd4, 5'(rows.size() + 1), imm}, op, rs, rt, 1'b0, 1'b1);
   endtask

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Differing sign bits decide the order on their own
   function automatic logic [31:0] less_signed(logic [31:0] a, logic [31:0] b);
      if (a[31] != b[31])
         return {31'd0, a[31]};
      return {31'd0, a < b};
   endfunction

   // Logical shift with the vacated top bits copying bit 31
   function automatic logic [31:0] shift_right_arith(logic [31:0] v, logic [4:0] n);
      logic [31:0] fill;
      fill = v[31] ? ~(32'hffff_ffff >> n) : 32'h0000_0000;
      return (v >> n) | fill;
   endfunction

   function automatic logic [31:0] model_result(logic [31:0] ins, logic [2:0] op,
                                                logic [31:0] rs, logic [31:0] rt);
      logic [31:0] se, ze;
      logic [4:0] sh, vs;
      se = {{16{ins[15]}}, ins[15:0]};
      ze = {16'h0000, ins[15:0]};
      sh = ins[10:6];
      vs = rs[4:0];                        // Variable shifts see 5 bits
      case (op)
         mips_pkg::OP_RTYPE:
            case (ins[5:0])
               mips_pkg::FUNCT_SUBU: return rs - rt;
               mips_pkg::FUNCT_AND:  return rs & rt;
               mips_pkg::FUNCT_OR:   return rs | rt;
               mips_pkg::FUNCT_XOR:  return rs ^ rt;
               mips_pkg::FUNCT_NOR:  return ~(rs | rt);
               mips_pkg::FUNCT_SLT:  return less_signed(rs, rt);
               mips_pkg::FUNCT_SLL:  return rt << sh;
               mips_pkg::FUNCT_SRL:  return rt >> sh;
               mips_pkg::FUNCT_SRA:  return shift_right_arith(rt, sh);
               mips_pkg::FUNCT_SLLV: return rt << vs;
               mips_pkg::FUNCT_SRLV: return rt >> vs;
               mips_pkg::FUNCT_SRAV: return shift_right_arith(rt, vs);
               default:              return rs + rt; // ADDU and unknown
            endcase
         mips_pkg::OP_ADD:  return rs + se;
         mips_pkg::OP_SUB:  return rs - rt;
         mips_pkg::OP_ANDI: return rs & ze;
         mips_pkg::OP_ORI:  return rs | ze;
         mips_pkg::OP_XORI: return rs ^ ze;
         mips_pkg::OP_SLTI: return less_signed(rs, se);
         default:           return {ins[15:0], 16'h0000}; // LUI
      endcase
   endfunction

   ////////////////////////////////////////
   // Checking
   ////////////////////////////////////////

   task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
      checks++;
      if (act !== exp)
      begin
         $display("mismatch at %0d ns: %s expected %h actual %h", $time, name, exp, act);
         errors++;
         row_errs++;
      end
   endtask

   task automatic check_outputs();
      check_value("o_valid", 32'(exp_valid), 32'(o_valid));
      check_value("o_result", exp_result, o_result);
      check_value("o_zero", 32'(exp_zero), 32'(o_zero));
      check_value("o_rt_data", exp_rt, o_rt_data);
      check_value("o_write_reg", 32'(exp_wreg), 32'(o_write_reg));
   endtask

   task automatic clear_expected();
      {exp_valid, exp_zero, exp_result, exp_rt, exp_wreg} = '0;
   endtask

   task automatic report_row(string name);
      if (row_errs == 0)
         $display("%0d ns %s ok", $time, name);
      else
         $display("%0d ns %s wrong, %0d mismatches", $time, name, row_errs);
   endtask

   // Drive on the falling edge and check one edge later
   task automatic apply_row(row_t r);
      {i_instr, i_alu_op, i_rs_data, i_rt_data, i_stall, i_valid} =
         {r.instr, r.op, r.rs, r.rt, r.stall, r.valid};
      if (!r.stall)
      begin
         exp_valid  = r.valid;
         exp_result = model_result(r.instr, r.op, r.rs, r.rt);
         exp_zero   = (exp_result == 32'd0);
         exp_rt     = r.rt;
         exp_wreg   = (r.op == mips_pkg::OP_RTYPE) ? r.instr[15:11] : r.instr[20:16];
      end
      @(negedge clock);
      row_errs = 0;
      check_outputs();
      report_row(r.name);
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("run did not finish within %0d ns", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

   initial
   begin
      int cycles;
      logic [2:0] cls;
      logic [5:0] fn;
      logic [31:0] a, b;
      logic [15:0] imm;
      row_t again;
      {i_valid, i_stall, i_alu_op, i_instr, i_rs_data, i_rt_data, rst_tb} = '0;
      {errors, checks, row_errs} = '0;
      lfsr_state = 32'h30f0;
      clear_expected();

      // Directed rows
      add_r("addu", mips_pkg::FUNCT_ADDU, 5'd0, 32'h1234_5678, 32'h1111_1111);
      add_r("subu", mips_pkg::FUNCT_SUBU, 5'd0, 32'd5, 32'd9);
      add_r("and", mips_pkg::FUNCT_AND, 5'd0, 32'hff00_ff00, 32'h0ff0_0ff0);
      add_r("or", mips_pkg::FUNCT_OR, 5'd0, 32'hff00_ff00, 32'h0ff0_0ff0);
      add_r("xor", mips_pkg::FUNCT_XOR, 5'd0, 32'hff00_ff00, 32'h0ff0_0ff0);
      add_r("nor", mips_pkg::FUNCT_NOR, 5'd0, 32'hff00_ff00, 32'h0ff0_0ff0);
      add_r("slt_neg", mips_pkg::FUNCT_SLT, 5'd0, 32'hffff_fffb, 32'd3);
      add_r("slt_pos", mips_pkg::FUNCT_SLT, 5'd0, 32'd3, 32'hffff_fffb);
      add_r("funct_unk", 6'h3f, 5'd0, 32'd40, 32'd2);
      add_r("sll", mips_pkg::FUNCT_SLL, 5'd4, 32'hdead_beef, 32'h0000_00f1);
      add_r("srl", mips_pkg::FUNCT_SRL, 5'd8, 32'hdead_beef, 32'h8000_0000);
      add_r("sra", mips_pkg::FUNCT_SRA, 5'd4, 32'hdead_beef, 32'h8000_00f0);
      add_r("sllv", mips_pkg::FUNCT_SLLV, 5'd9, 32'hffff_ffe3, 32'd1);
      add_r("srlv", mips_pkg::FUNCT_SRLV, 5'd9, 32'h0000_0024, 32'hf000_0000);
      add_r("srav", mips_pkg::FUNCT_SRAV, 5'd9, 32'hffff_ff3f, 32'h8000_0000);
      add_i("addi", mips_pkg::OP_ADD, 16'hfff0, 32'd100, 32'h0bad_0001);
      add_i("slti", mips_pkg::OP_SLTI, 16'hfff6, 32'd5, 32'd0);
      add_i("andi", mips_pkg::OP_ANDI, 16'h8f0f, 32'hffff_ffff, 32'd0);
      add_i("ori", mips_pkg::OP_ORI, 16'h8001, 32'h1234_0000, 32'd0);
      add_i("xori", mips_pkg::OP_XORI, 16'hffff, 32'hffff_0000, 32'd0);
      add_i("lui", mips_pkg::OP_LUI, 16'hbeef, 32'h0000_1234, 32'd0);
      add_i("beq_eq", mips_pkg::OP_SUB, 16'h0010, 32'h5a5a_5a5a, 32'h5a5a_5a5a);
      add_i("beq_ne", mips_pkg::OP_SUB, 16'h0010, 32'h5a5a_5a5a, 32'h5a5a_5a5b);
      add_r("hold_src", mips_pkg::FUNCT_ADDU, 5'd0, 32'd7, 32'd8);
      add_row("stall_1", 32'h0000_1821, mips_pkg::OP_RTYPE, 32'd1, 32'd2, 1'b1, 1'b1);
      add_row("stall_2", 32'h0000_2023, mips_pkg::OP_RTYPE, 32'd3, 32'd4, 1'b1, 1'b0);
      add_r("release", mips_pkg::FUNCT_OR, 5'd0, 32'h00f0_0000, 32'h0000_000f);
      add_row("bubble", 32'h0000_2824, mips_pkg::OP_RTYPE, 32'd6, 32'd6, 1'b0, 1'b0);

      // LFSR rows with occasional stall and bubble
      for (int k = 0; k < RANDOM_ROWS; k++)
      begin
         cls = 3'(rand_bits(3));
         fn  = FUNCT_SET[int'(rand_bits(4)) % 14];
         a   = rand_bits(32);
         b   = rand_bits(32);
         imm = 16'(rand_bits(16));
         if (cls == mips_pkg::OP_RTYPE)
            add_row($sformatf("rand_%0d", k), {6'h00, 10'(rand_bits(10)), 5'(rand_bits(5)),
                    5'(rand_bits(5)), fn}, cls, a, b, rand_bits(2) == 0, 1'(rand_bits(1)));
         else
            add_row($sformatf("rand_%0d", k), {6'(rand_bits(6)), 10'(rand_bits(10)), imm},
                    cls, a, b, rand_bits(2) == 0, 1'(rand_bits(1)));
      end

      // Outputs read zero throughout power-on reset
      cycles = 0;
      do
      begin
         @(negedge clock);
         cycles++;
         check_outputs();
      end
      while (rst_gen && cycles < RESET_LIMIT);
      if (rst_gen)
      begin
         $display("reset was not released within %0d cycles", RESET_LIMIT);
         errors++;
         row_errs++;
      end
      report_row("power_on_reset");

      foreach (rows[k])
         apply_row(rows[k]);

      // Mid-run reset with a valid item on the inputs
      row_errs = 0;
      {i_instr, i_alu_op, i_rs_data, i_rt_data, i_valid} =
         {rows[0].instr, rows[0].op, rows[0].rs, rows[0].rt, 1'b1};
      rst_tb = 1'b1;
      clear_expected();
      repeat (2)
      begin
         @(negedge clock);
         check_outputs();
      end
      report_row("mid_reset");
      rst_tb = 1'b0;
      again = rows[0];
      again.name = "after_reset";
      apply_row(again);

      $display("done: %0d rows, %0d checks, %0d errors", rows.size() + 3, checks, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
